// File: build.f
+incdir+src
src/pixel_pkg.sv
src/csr_pkg.sv
src/stream_reg.sv
src/ball_classifier.sv
src/pixel_recolour.sv
src/frame_tracker.sv
src/msg_fifo.sv
src/imgproc_csr.sv
src/eee_imgproc.sv
test/tb_eee_imgproc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the ball tracker testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_eee_imgproc -f build.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& echo "simulation run passed" \
	|| { echo "simulation run failed"; exit 1; }

// File: src/ball_classifier.sv
/* ball classifier with RGB to HSV, red and teal thresholds
   and run-length confirmation */
`include "imgproc_settings.svh"

module ball_classifier (
	input  logic            clk,
	input  logic            reset_n,
	input  pixel_pkg::rgb_t pixel,
	input  logic            beat,
	input  logic            sop,
	output logic            hit_red,
	output logic            hit_teal
);
	// detections needed, indexed by ball_e
	localparam int RUN [2] = '{`RED_RUN, `TEAL_RUN};

	pixel_pkg::channel_t red, green, blue;
	pixel_pkg::channel_t value, min_c, hue, sat;
	logic [1:0] det;
	logic [2:0] run_cnt [2];

	assign {red, green, blue} = pixel;

	////////////////////////////////////////////////////////////
	// hsv
	////////////////////////////////////////////////////////////

	// largest and smallest channel
	assign value = (red > green) ? ((red > blue) ? red : blue) : ((green > blue) ? green : blue);
	assign min_c = (red < green) ? ((red < blue) ? red : blue) : ((green < blue) ? green : blue);

	always_comb begin
		int d;
		int h2;
		int s;
		d = int'(value) - int'(min_c);
		// hue in degrees by sector of the largest channel
		if (d == 0) begin
			h2 = 0;
		end else if (value != red) begin
			if (value != green) begin
				// blue sector
				h2 = (240 * d + 60 * (int'(red) - int'(green))) / d;
			end else begin
				// green sector
				h2 = (120 * d + 60 * (int'(blue) - int'(red))) / d;
			end
		end else if (blue < green) begin
			h2 = 60 * (int'(green) - int'(blue)) / d;
		end else begin
			// red sector wrapping toward 360
			h2 = (360 * d + 60 * (int'(green) - int'(blue))) / d;
		end
		// stored in half degrees, 0 to 180
		hue = pixel_pkg::channel_t'(h2 >> 1);
		// black has no saturation
		s = (value == '0) ? 0 : d * 255 / int'(value);
		sat = pixel_pkg::channel_t'(s);
	end

	////////////////////////////////////////////////////////////
	// thresholds
	////////////////////////////////////////////////////////////

	// red wraps around hue zero
	assign det[pixel_pkg::BALL_RED] =
		(((hue >= 150 && hue <= 180) || hue <= 6) && sat > 84 && value > 245)
		|| (hue <= 6 && ((value > 229 && sat > 17 && sat < 155) || (value > 210 && sat > 130)))
		|| ((hue >= 160 && hue <= 180) && ((sat >= 76 && value >= 249) || (sat >= 102 && value >= 140)))
		|| (((hue >= 160 && hue <= 180) || hue <= 4)
			&& sat > 140 && sat <= 179 && value >= 89 && value <= 106)
		|| (((hue >= 172 && hue <= 180) || hue <= 6)
			&& ((value > 105 && sat > 102) || (sat > 82 && value > 168)));

	// two teal bands, bright and washed out
	assign det[pixel_pkg::BALL_TEAL] =
		((hue >= 60 && hue <= 85) && sat > 100 && sat < 200 && value > 110 && value < 245)
		|| ((hue >= 53 && hue <= 80) && sat > 80 && sat < 114 && value > 60);

	////////////////////////////////////////////////////////////
	// run confirmation
	////////////////////////////////////////////////////////////

	// previous detections in a row, saturating
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (!reset_n || (beat && sop)) begin
				run_cnt[i] <= '0;
			end else if (beat) begin
				if (!det[i]) begin
					run_cnt[i] <= '0;
				end else if (run_cnt[i] < RUN[i] - 1) begin
					run_cnt[i] <= run_cnt[i] + 3'd1;
				end
			end
		end
	end

	assign hit_red = det[pixel_pkg::BALL_RED]
		&& (run_cnt[pixel_pkg::BALL_RED] >= RUN[pixel_pkg::BALL_RED] - 1);
	assign hit_teal = det[pixel_pkg::BALL_TEAL]
		&& (run_cnt[pixel_pkg::BALL_TEAL] >= RUN[pixel_pkg::BALL_TEAL] - 1);

endmodule

// File: src/csr_pkg.sv
/* register map, message writer states and message word type */
package csr_pkg;

	// processor register addresses
	typedef enum logic [2:0] {
		ADDR_STATUS = 3'd0,
		ADDR_MSG    = 3'd1,
		ADDR_ID     = 3'd2,
		ADDR_BBCOL  = 3'd3
	} csr_addr_e;

	// message writer, one word per state after idle
	typedef enum logic [1:0] {
		MSG_IDLE,
		MSG_ID,
		MSG_RED_BOX,
		MSG_TEAL_BOX
	} msg_state_e;

	// one FIFO word
	typedef logic [31:0] msg_word_t;

endpackage

// File: src/eee_imgproc.sv
/* ball tracker top with stream slices, classifier, recolour,
   frame tracker, message FIFO and register block */
module eee_imgproc (
	input  logic            clk,
	input  logic            reset_n,
	// processor bus
	input  logic            s_chipselect,
	input  logic            s_read,
	input  logic            s_write,
	input  logic [2:0]      s_address,
	input  logic [31:0]     s_writedata,
	output logic [31:0]     s_readdata,
	// pixel sink
	input  pixel_pkg::rgb_t sink_data,
	input  logic            sink_valid,
	output logic            sink_ready,
	input  logic            sink_sop,
	input  logic            sink_eop,
	// pixel source
	output pixel_pkg::rgb_t source_data,
	output logic            source_valid,
	input  logic            source_ready,
	output logic            source_sop,
	output logic            source_eop,
	// recolour enable
	input  logic            mode
);
	// pixel plus sop and eop
	localparam int BEAT_W = $bits(pixel_pkg::rgb_t) + 2;

	pixel_pkg::rgb_t in_pixel, out_pixel, bb_col;
	logic in_valid, in_ready, in_sop, in_eop, beat;
	logic hit_red, hit_teal, packet_video;
	pixel_pkg::coord_t x, red_left, red_right, teal_left, teal_right;
	csr_pkg::msg_word_t msg_data, fifo_data;
	logic msg_wr, fifo_rd, fifo_flush, fifo_empty;
	logic [8:0] fifo_count;

	// beat moves from in_reg to out_reg
	assign beat = in_valid & in_ready;

	////////////////////////////////////////////////////////////
	// stream path
	////////////////////////////////////////////////////////////

	stream_reg #(.DATA_W(BEAT_W)) in_reg (
		.clk(clk), .reset_n(reset_n),
		.in_valid(sink_valid), .in_ready(sink_ready),
		.in_data({sink_data, sink_sop, sink_eop}),
		.out_valid(in_valid), .out_ready(in_ready),
		.out_data({in_pixel, in_sop, in_eop})
	);

	ball_classifier u_ball_classifier (
		.clk(clk), .reset_n(reset_n),
		.pixel(in_pixel), .beat(beat), .sop(in_sop),
		.hit_red(hit_red), .hit_teal(hit_teal)
	);

	pixel_recolour u_pixel_recolour (
		.pixel(in_pixel), .sop(in_sop), .packet_video(packet_video), .mode(mode),
		.hit_red(hit_red), .hit_teal(hit_teal), .x(x),
		.red_left(red_left), .red_right(red_right),
		.teal_left(teal_left), .teal_right(teal_right),
		.bb_col(bb_col), .pixel_out(out_pixel)
	);

	stream_reg #(.DATA_W(BEAT_W)) out_reg (
		.clk(clk), .reset_n(reset_n),
		.in_valid(in_valid), .in_ready(in_ready),
		.in_data({out_pixel, in_sop, in_eop}),
		.out_valid(source_valid), .out_ready(source_ready),
		.out_data({source_data, source_sop, source_eop})
	);

	////////////////////////////////////////////////////////////
	// tracking and processor side
	////////////////////////////////////////////////////////////

	// type nibble sits in the blue channel of the sop beat
	frame_tracker u_frame_tracker (
		.clk(clk), .reset_n(reset_n),
		.beat(beat), .sop(in_sop), .eop(in_eop), .blue_low(in_pixel[3:0]),
		.hit_red(hit_red), .hit_teal(hit_teal), .fifo_count(fifo_count),
		.x(x), .packet_video(packet_video),
		.red_left(red_left), .red_right(red_right),
		.teal_left(teal_left), .teal_right(teal_right),
		.msg_data(msg_data), .msg_wr(msg_wr)
	);

	msg_fifo u_msg_fifo (
		.clk(clk), .reset_n(reset_n), .flush(fifo_flush),
		.wr(msg_wr), .wr_data(msg_data),
		.rd(fifo_rd), .rd_data(fifo_data),
		.count(fifo_count), .empty(fifo_empty)
	);

	imgproc_csr u_imgproc_csr (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata),
		.fifo_data(fifo_data), .fifo_count(fifo_count), .fifo_empty(fifo_empty),
		.fifo_rd(fifo_rd), .fifo_flush(fifo_flush), .bb_col(bb_col)
	);

endmodule

// File: src/frame_tracker.sv
/* column counter, packet type, per-colour extents,
   frame latch and message writer FSM */
`include "imgproc_settings.svh"

module frame_tracker (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               beat,
	input  logic               sop,
	input  logic               eop,
	input  logic [3:0]         blue_low,
	input  logic               hit_red,
	input  logic               hit_teal,
	input  logic [8:0]         fifo_count,
	output pixel_pkg::coord_t  x,
	output logic               packet_video,
	output pixel_pkg::coord_t  red_left,
	output pixel_pkg::coord_t  red_right,
	output pixel_pkg::coord_t  teal_left,
	output pixel_pkg::coord_t  teal_right,
	output csr_pkg::msg_word_t msg_data,
	output logic               msg_wr
);
	localparam pixel_pkg::coord_t X_LAST = pixel_pkg::coord_t'(`IMAGE_W - 1);

	pixel_pkg::coord_t red_min, red_max, teal_min, teal_max;
	pixel_pkg::coord_t red_start, teal_start;
	logic frame_end;
	logic [7:0] frame_count;
	csr_pkg::msg_state_e state;

	// column
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			packet_video <= 1'b0;
		end else if (beat) begin
			if (sop) begin
				x <= '0;
				// video packets carry a zero type nibble
				packet_video <= (blue_low == 4'h0);
			end else if (x == X_LAST) begin
				x <= '0;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// a hit confirms a run that began RUN-1 columns back
	assign red_start = (x >= `RED_RUN - 1) ? x - pixel_pkg::coord_t'(`RED_RUN - 1) : '0;
	assign teal_start = (x >= `TEAL_RUN - 1) ? x - pixel_pkg::coord_t'(`TEAL_RUN - 1) : '0;

	// extents of this frame
	always_ff @(posedge clk) begin
		if (!reset_n || (beat && sop)) begin
			red_min <= X_LAST;
			red_max <= '0;
			teal_min <= X_LAST;
			teal_max <= '0;
		end else if (beat) begin
			if (hit_red && red_start < red_min) red_min <= red_start;
			if (hit_red && x > red_max) red_max <= x;
			if (hit_teal && teal_start < teal_min) teal_min <= teal_start;
			if (hit_teal && x > teal_max) teal_max <= x;
		end
	end

	////////////////////////////////////////////////////////////
	// frame end and message writer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_end <= 1'b0;
			frame_count <= '0;
			state <= csr_pkg::MSG_IDLE;
			red_left <= X_LAST;
			red_right <= '0;
			teal_left <= X_LAST;
			teal_right <= '0;
		end else begin
			// extents settle one cycle after the last pixel
			frame_end <= beat && eop && !sop && packet_video;
			// three words back to back
			if (state != csr_pkg::MSG_IDLE) begin
				state <= csr_pkg::msg_state_e'(state + 2'd1);
			end
			if (frame_end) begin
				red_left <= red_min;
				red_right <= red_max;
				teal_left <= teal_min;
				teal_right <= teal_max;
				if (frame_count != '0) begin
					frame_count <= frame_count - 8'd1;
				end else if (state == csr_pkg::MSG_IDLE
					&& fifo_count < 9'(`MSG_BUF_DEPTH - 3)) begin
					// room for a whole message
					state <= csr_pkg::MSG_ID;
					frame_count <= 8'(`MSG_INTERVAL - 1);
				end
			end
		end
	end

	// word per state
	always_comb begin
		case (state)
			csr_pkg::MSG_ID: msg_data = `IMGPROC_ID;
			csr_pkg::MSG_RED_BOX: msg_data = {5'b0, red_left, 5'b0, red_right};
			csr_pkg::MSG_TEAL_BOX: msg_data = {5'b0, teal_left, 5'b0, teal_right};
			default: msg_data = '0;
		endcase
	end

	assign msg_wr = (state != csr_pkg::MSG_IDLE);

endmodule

// File: src/imgproc_csr.sv
/* memory-mapped registers for status, message reads, ID and box colour */
`include "imgproc_settings.svh"

module imgproc_csr (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               s_chipselect,
	input  logic               s_read,
	input  logic               s_write,
	input  logic [2:0]         s_address,
	input  logic [31:0]        s_writedata,
	output logic [31:0]        s_readdata,
	input  csr_pkg::msg_word_t fifo_data,
	input  logic [8:0]         fifo_count,
	input  logic               fifo_empty,
	output logic               fifo_rd,
	output logic               fifo_flush,
	output pixel_pkg::rgb_t    bb_col
);
	csr_pkg::csr_addr_e addr;
	logic [7:0] reg_status;
	logic rd_en, wr_en;
	// read strobe last cycle
	logic read_d;

	assign addr = csr_pkg::csr_addr_e'(s_address);
	assign rd_en = s_chipselect && s_read;
	assign wr_en = s_chipselect && s_write;

	// writes
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reg_status <= '0;
			bb_col <= `BB_COL_DEFAULT;
		end else if (wr_en) begin
			case (addr)
				csr_pkg::ADDR_STATUS: reg_status <= s_writedata[7:0];
				csr_pkg::ADDR_BBCOL: bb_col <= s_writedata[23:0];
				default: ;
			endcase
		end
	end

	// status bit 4 empties the FIFO in the write cycle
	assign fifo_flush = wr_en && (addr == csr_pkg::ADDR_STATUS) && s_writedata[4];

	// reads return a cycle after the strobe
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= '0;
			read_d <= 1'b0;
		end else begin
			read_d <= rd_en;
			if (rd_en) begin
				case (addr)
					csr_pkg::ADDR_STATUS: s_readdata <= {16'h0, fifo_count[7:0], reg_status};
					csr_pkg::ADDR_MSG: s_readdata <= fifo_data;
					csr_pkg::ADDR_ID: s_readdata <= `IMGPROC_ID;
					csr_pkg::ADDR_BBCOL: s_readdata <= {8'h0, bb_col};
					default: s_readdata <= '0;
				endcase
			end
		end
	end

	// one pop per msg read, on its first cycle
	assign fifo_rd = rd_en && !read_d && !fifo_empty && (addr == csr_pkg::ADDR_MSG);

endmodule

// File: src/imgproc_settings.svh
/* build constants for the ball tracker
   frame width, message pacing, FIFO depth, colours, ID word and run lengths */
`ifndef IMGPROC_SETTINGS_SVH
`define IMGPROC_SETTINGS_SVH

// frame width in pixels
`define IMAGE_W 640
// video frames between processor messages
`define MSG_INTERVAL 6
// message FIFO depth in words
`define MSG_BUF_DEPTH 256

// box colour out of reset
`define BB_COL_DEFAULT 24'h00ff00
// highlight colours
`define HL_RED 24'hff1000
`define HL_TEAL 24'h04bd42

// identification word
`define IMGPROC_ID 32'h1234EEE2

// consecutive detections before a hit
`define RED_RUN 4
`define TEAL_RUN 3

`endif

// File: src/msg_fifo.sv
/* circular message FIFO with fill count and flush */
`include "imgproc_settings.svh"

module msg_fifo (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               flush,
	input  logic               wr,
	input  csr_pkg::msg_word_t wr_data,
	input  logic               rd,
	output csr_pkg::msg_word_t rd_data,
	output logic [8:0]         count,
	output logic               empty
);
	localparam int AW = $clog2(`MSG_BUF_DEPTH);

	csr_pkg::msg_word_t mem [`MSG_BUF_DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic do_wr, do_rd;

	// writes to a full buffer are dropped
	assign do_wr = wr && (count != 9'(`MSG_BUF_DEPTH));
	assign do_rd = rd && !empty;
	assign empty = (count == '0);
	// head word
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			count <= count + {8'b0, do_wr} - {8'b0, do_rd};
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

endmodule

// File: src/pixel_pkg.sv
/* pixel channel, RGB, column and ball colour types */
package pixel_pkg;

	// one colour channel
	typedef logic [7:0] channel_t;

	// red in the high byte, blue in the low byte
	typedef logic [23:0] rgb_t;

	// column in a frame line
	typedef logic [10:0] coord_t;

	// tracked ball colours
	typedef enum logic {
		BALL_RED  = 1'b0,
		BALL_TEAL = 1'b1
	} ball_e;

endpackage

// File: src/pixel_recolour.sv
/* grey recolouring, ball highlight and box overlay */
`include "imgproc_settings.svh"

module pixel_recolour (
	input  pixel_pkg::rgb_t   pixel,
	input  logic              sop,
	input  logic              packet_video,
	input  logic              mode,
	input  logic              hit_red,
	input  logic              hit_teal,
	input  pixel_pkg::coord_t x,
	input  pixel_pkg::coord_t red_left,
	input  pixel_pkg::coord_t red_right,
	input  pixel_pkg::coord_t teal_left,
	input  pixel_pkg::coord_t teal_right,
	input  pixel_pkg::rgb_t   bb_col,
	output pixel_pkg::rgb_t   pixel_out
);
	localparam pixel_pkg::coord_t X_LAST = pixel_pkg::coord_t'(`IMAGE_W - 1);

	pixel_pkg::channel_t grey;
	pixel_pkg::rgb_t shaded;
	logic edge_red, edge_teal;

	// half green plus quarter red plus quarter blue
	assign grey = {1'b0, pixel[15:9]} + {2'b0, pixel[23:18]} + {2'b0, pixel[7:2]};

	// red highlight wins
	assign shaded = hit_red ? `HL_RED : (hit_teal ? `HL_TEAL : {grey, grey, grey});

	// extents still at their reset values mean no ball last frame
	assign edge_red = (x == red_left && red_left != X_LAST) || (x == red_right && red_right != '0);
	assign edge_teal = (x == teal_left && teal_left != X_LAST)
		|| (x == teal_right && teal_right != '0);

	// descriptor beats and non-video packets go through untouched
	assign pixel_out = (mode && !sop && packet_video)
		? ((edge_red || edge_teal) ? bb_col : shaded) : pixel;

endmodule

// File: src/stream_reg.sv
/* one-beat valid/ready register slice */
module stream_reg #(
	parameter int DATA_W = 26
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  logic [DATA_W-1:0] in_data,
	output logic              out_valid,
	input  logic              out_ready,
	output logic [DATA_W-1:0] out_data
);
	// slot holds a beat
	logic full;
	// low for the first cycle out of reset
	logic live;

	// room when empty or when the held beat leaves this cycle
	assign in_ready = live & (~full | out_ready);
	assign out_valid = full;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			live <= 1'b0;
			full <= 1'b0;
		end else begin
			live <= 1'b1;
			// refill or drain
			if (in_ready) begin
				full <= in_valid;
			end
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

// File: test/tb_eee_imgproc.sv
/* testbench for the ball tracker top
   frame table through the pixel stream, register checks and timeout */
`include "imgproc_settings.svh"

module tb_eee_imgproc;
	timeunit 1ns;
	timeprecision 100ps;

	// register work after a frame has fully left the DUT
	localparam int ACT_NONE = 0;
	localparam int ACT_FIRST_MSG = 1;
	localparam int ACT_SET_BBCOL = 2;
	localparam int ACT_NO_MSG = 3;
	localparam int ACT_FLUSH = 4;

	logic clk;
	logic reset_n;
	logic s_chipselect, s_read, s_write;
	logic [2:0] s_address;
	logic [31:0] s_writedata, s_readdata;
	logic [23:0] sink_data, source_data;
	logic sink_valid, sink_ready, sink_sop, sink_eop;
	logic source_valid, source_sop, source_eop;
	logic source_ready = 1'b0;
	logic mode;

	// frame table, one entry per frame
	bit frame_video [$];
	bit frame_mode [$];
	logic [23:0] frame_box [$];
	int frame_action [$];
	string frame_in [$];
	string frame_exp [$];

	integer seed = 22;
	int rnd;
	int errors = 0;
	int checks = 0;
	int cycle_limit = 0;

	eee_imgproc u_eee_imgproc (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata),
		.sink_data(sink_data), .sink_valid(sink_valid), .sink_ready(sink_ready),
		.sink_sop(sink_sop), .sink_eop(sink_eop),
		.source_data(source_data), .source_valid(source_valid),
		.source_ready(source_ready), .source_sop(source_sop), .source_eop(source_eop),
		.mode(mode)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// random back-pressure on the source side
	always @(posedge clk) begin
		rnd = $random(seed);
		source_ready <= rnd[0];
	end

	////////////////////////////////////////////////////////////
	// expected values
	////////////////////////////////////////////////////////////

	// input pixel classes
	function automatic logic [23:0] class_pixel(input byte code);
		case (code)
			"R": return 24'hff0000;
			"T": return 24'h64c8aa;
			default: return 24'h808080;
		endcase
	endfunction

	// half green, quarter red, quarter blue
	function automatic logic [23:0] grey_of(input logic [23:0] p);
		logic [7:0] g;
		g = (p[15:8] >> 1) + (p[23:16] >> 2) + (p[7:0] >> 2);
		return {g, g, g};
	endfunction

	// upper case passes through, r and t are greyed balls,
	// H and h highlights, B the box colour of the frame
	function automatic logic [23:0] expected_pixel(input byte code, input logic [23:0] box);
		case (code)
			"r": return grey_of(class_pixel("R"));
			"t": return grey_of(class_pixel("T"));
			"H": return 24'hff1000;
			"h": return 24'h04bd42;
			"B": return box;
			default: return class_pixel(code);
		endcase
	endfunction

	// sop beat, zero type nibble for video
	function automatic logic [23:0] descriptor_word(input bit video);
		return video ? 24'h000000 : 24'h00000f;
	endfunction

	// 5 zero bits, left, 5 zero bits, right
	function automatic logic [31:0] box_word(input int left, input int right);
		return 32'((left << 16) | right);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stream and bus drivers
	////////////////////////////////////////////////////////////

	task automatic init_inputs();
		reset_n <= 1'b0;
		s_chipselect <= 1'b0;
		s_read <= 1'b0;
		s_write <= 1'b0;
		s_address <= 3'd0;
		s_writedata <= 32'h0;
		sink_data <= 24'h0;
		sink_valid <= 1'b0;
		sink_sop <= 1'b0;
		sink_eop <= 1'b0;
		mode <= 1'b0;
	endtask

	// descriptor beat then one beat per pixel, each held until taken
	task automatic send_frame(input int f);
		string pix;
		int n;
		pix = frame_in[f];
		n = pix.len();
		mode <= frame_mode[f];
		for (int i = 0; i <= n; i++) begin
			sink_valid <= 1'b1;
			sink_sop <= (i == 0);
			sink_eop <= (i == n);
			sink_data <= (i == 0) ? descriptor_word(frame_video[f]) : class_pixel(pix[i-1]);
			do @(posedge clk); while (!sink_ready);
		end
		sink_valid <= 1'b0;
		sink_sop <= 1'b0;
		sink_eop <= 1'b0;
	endtask

	// output beats in order, whenever they are taken
	task automatic collect_frame(input int f);
		string exp;
		int n;
		logic [23:0] exp_data;
		exp = frame_exp[f];
		n = exp.len();
		for (int i = 0; i <= n; i++) begin
			exp_data = (i == 0) ? descriptor_word(frame_video[f])
				: expected_pixel(exp[i-1], frame_box[f]);
			do @(posedge clk); while (!(source_valid && source_ready));
			check_value("source_data", 32'(exp_data), 32'(source_data));
			check_value("source_sop", 32'(i == 0), 32'(source_sop));
			check_value("source_eop", 32'(i == n), 32'(source_eop));
		end
	endtask

	// data comes back one cycle after the strobe
	task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
		s_chipselect <= 1'b1;
		s_read <= 1'b1;
		s_address <= addr;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_read <= 1'b0;
		@(posedge clk);
		data = s_readdata;
	endtask

	task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
		s_chipselect <= 1'b1;
		s_write <= 1'b1;
		s_address <= addr;
		s_writedata <= data;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_write <= 1'b0;
	endtask

	// message words land a few cycles after the last pixel
	task automatic wait_fifo_count(input logic [7:0] want, output logic [31:0] status);
		int tries;
		tries = 0;
		read_reg(csr_pkg::ADDR_STATUS, status);
		while (status[15:8] != want && tries < 8) begin
			read_reg(csr_pkg::ADDR_STATUS, status);
			tries++;
		end
	endtask

	task automatic run_action(input int code);
		logic [31:0] rd;
		case (code)
			ACT_FIRST_MSG: begin
				wait_fifo_count(8'd3, rd);
				check_value("status", 32'h0000_0300, rd);
				read_reg(csr_pkg::ADDR_MSG, rd);
				check_value("msg id", 32'h1234_EEE2, rd);
				read_reg(csr_pkg::ADDR_MSG, rd);
				check_value("msg red box", box_word(3, 8), rd);
				// no teal seen, extents stay at reset values
				read_reg(csr_pkg::ADDR_MSG, rd);
				check_value("msg teal box", box_word(`IMAGE_W - 1, 0), rd);
				read_reg(csr_pkg::ADDR_ID, rd);
				check_value("id", 32'h1234_EEE2, rd);
			end
			ACT_SET_BBCOL: write_reg(csr_pkg::ADDR_BBCOL, 32'h0000_00ff);
			ACT_NO_MSG: begin
				// long enough for a message to land, none may
				wait_fifo_count(8'd3, rd);
				check_value("status", 32'h0, rd);
			end
			ACT_FLUSH: begin
				wait_fifo_count(8'd3, rd);
				check_value("status", 32'h0000_0300, rd);
				// bit 4 empties the FIFO
				write_reg(csr_pkg::ADDR_STATUS, 32'h0000_0010);
				read_reg(csr_pkg::ADDR_STATUS, rd);
				check_value("status", 32'h0000_0010, rd);
			end
			default: ;
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// frame table
	////////////////////////////////////////////////////////////

	task automatic add_frame(input bit video, input bit mode_bit, input logic [23:0] box,
		input int action, input string pix, input string exp);
		frame_video.push_back(video);
		frame_mode.push_back(mode_bit);
		frame_box.push_back(box);
		frame_action.push_back(action);
		frame_in.push_back(pix);
		frame_exp.push_back(exp);
	endtask

	task automatic build_table();
		// first video frame, pass through, red at columns 3 to 8
		add_frame(1'b1, 1'b0, `BB_COL_DEFAULT, ACT_FIRST_MSG, "GGGRRRRRRGGG", "GGGRRRRRRGGG");
		// edges of the last box win over greying
		add_frame(1'b1, 1'b1, `BB_COL_DEFAULT, ACT_SET_BBCOL, "GGGRRRRRRG", "GGGBrrHHBG");
		add_frame(1'b1, 1'b1, 24'h0000ff, ACT_NONE, "GGGRRRRRRG", "GGGBrrHHBG");
		// red and teal runs clear of the box edges
		add_frame(1'b1, 1'b1, 24'h0000ff, ACT_NONE, "GGGGGGGGGRRRRRGTTTTG",
			"GGGBGGGGBrrrHHGtthhG");
		// non-video packet
		add_frame(1'b0, 1'b1, 24'h0000ff, ACT_NONE, "RRRRTTTG", "RRRRTTTG");
		// short video frames up to the next message
		add_frame(1'b1, 1'b0, 24'h0000ff, ACT_NONE, "GG", "GG");
		add_frame(1'b1, 1'b0, 24'h0000ff, ACT_NO_MSG, "TT", "TT");
		add_frame(1'b1, 1'b0, 24'h0000ff, ACT_FLUSH, "RG", "RG");
	endtask

	// main sequence
	initial begin
		string pix;
		int total;
		total = 0;
		init_inputs();
		build_table();
		foreach (frame_in[f]) begin
			pix = frame_in[f];
			total += pix.len() + 1;
		end
		cycle_limit = 4 * total + 200;
		repeat (4) @(posedge clk);
		check_value("sink_ready", 32'h0, 32'(sink_ready));
		check_value("source_valid", 32'h0, 32'(source_valid));
		reset_n <= 1'b1;
		@(posedge clk);
		for (int f = 0; f < frame_in.size(); f++) begin
			fork
				send_frame(f);
				collect_frame(f);
			join
			run_action(frame_action[f]);
		end
		$display("checks run %0d, mismatches %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		int cycles;
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the stream or a register access stalled", cycles);
		$display("checks run %0d, mismatches %0d", checks, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
